//--- test/sd_dma_testdata.txt
# base(hex) partial win_start win_end writes final_addr(hex) restart
# windows are byte indices, restart issues a second start while busy
0000 0 0 0 512 0200 0
1200 1 16 48 32 1220 0
2000 1 0 512 512 2200 0
3000 1 500 512 12 300c 0
4000 0 0 0 512 4200 1
5000 1 100 101 1 5001 1
6000 1 40 40 0 6000 0

//--- vlog.f
verilog/sd_bus_pkg.sv
verilog/sram_pkg.sv
verilog/sd_dma_ctrl_if.sv
verilog/dma_ctrl.sv
verilog/sd_dma.sv
verilog/sram_addr_gen.sv
verilog/sd_dma_top.sv
test/sd_dma_checker.sv
test/tb_sd_dma.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_sd_dma -f vlog.f
	./obj_dir/Vtb_sd_dma | tee /dev/stderr | grep "Verification passed" > /dev/null

clean:
	rm -rf obj_dir

//--- test/tb_sd_dma.sv
`timescale 1ns/10ps

module tb_sd_dma;

  localparam string TEST_FILE  = "test/sd_dma_testdata.txt";
  localparam int    MAX_TESTS  = 16;
  localparam int    TEST_LIMIT = 4400;
  localparam int    LIMIT_PAD  = 200;

  logic                 CLK = 1'b0;
  logic                 rst;
  logic                 mcu_wr;
  sram_pkg::mcu_reg_t   mcu_reg;
  sram_pkg::mcu_data_t  mcu_wdata;
  sd_bus_pkg::nibble_t  sd_dat;
  logic                 sd_clk;
  logic                 sd_clk_oe;
  sram_pkg::sram_addr_t sram_addr;
  sram_pkg::byte_t      sram_data;
  logic                 sram_we_n;
  logic                 dma_busy;
  int                   chk_errors;
  int                   chk_writes;

  // One row per test with base, partial, win_start, win_end, writes, final address and restart
  int     tests [MAX_TESTS][7];
  int     n_tests = 0;
  int     passed = 0;
  int     failed = 0;
  int     cycles = 0;
  int     limit = 0;
  integer seed = 32'h4614;
  logic   clk_seen = 1'b0;

  always #10 CLK = ~CLK;

  sd_dma_top u_dut (.*);

  sd_dma_checker u_checker (.*, .errors(chk_errors), .writes(chk_writes));

  always @(posedge CLK) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  // Card puts out the next nibble once sd_clk has fallen
  always @(negedge CLK) begin
    if (clk_seen && !sd_clk) begin
      sd_dat = sd_bus_pkg::nibble_t'($random(seed));
    end
    clk_seen = sd_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register writes and per-test bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_reg(input sram_pkg::mcu_reg_t sel, input int value);
    @(negedge CLK);
    mcu_wr = 1'b1;
    mcu_reg = sel;
    mcu_wdata = sram_pkg::mcu_data_t'(value);
    @(negedge CLK);
    mcu_wr = 1'b0;
  endtask

  task automatic expect_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual, inout int bad);
    if (expected !== actual) begin
      $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      bad++;
    end
  endtask

  task automatic close_test(input string label, input int bad);
    if (bad == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("%s: %s", label, (bad == 0) ? "ok" : "FAILED");
  endtask

  task automatic load_tests();
    int    fd;
    int    got;
    string line;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      got = $fgets(line, fd);
      if (got > 0 && line.getc(0) != "#") begin
        got = $sscanf(line, "%h %d %d %d %d %h %d", tests[n_tests][0], tests[n_tests][1],
                      tests[n_tests][2], tests[n_tests][3], tests[n_tests][4],
                      tests[n_tests][5], tests[n_tests][6]);
        if (got == 7) begin
          n_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int i);
    int w0;
    int e0;
    int bad;
    w0 = chk_writes;
    e0 = chk_errors;
    bad = 0;
    write_reg(sram_pkg::REG_BASE, tests[i][0]);
    write_reg(sram_pkg::REG_WIN_START, tests[i][2]);
    write_reg(sram_pkg::REG_WIN_END, tests[i][3]);
    write_reg(sram_pkg::REG_CMD, tests[i][1] * 2 + 1);
    while (!dma_busy) @(negedge CLK);
    // Second start in the middle of the block
    if (tests[i][6] != 0) begin
      repeat (300) @(negedge CLK);
      write_reg(sram_pkg::REG_CMD, 3);
    end
    while (dma_busy) @(negedge CLK);
    // Checker closes the block on the next CLK
    @(negedge CLK);
    expect_value("write count", tests[i][4], chk_writes - w0, bad);
    expect_value("sram_addr", tests[i][5], sram_addr, bad);
    bad += chk_errors - e0;
    close_test($sformatf("test %0d base %h window %0d..%0d partial %0d", i,
                         tests[i][0], tests[i][2], tests[i][3], tests[i][1]), bad);
  endtask

  initial begin
    int bad;
    rst = 1'b1;
    mcu_wr = 1'b0;
    mcu_reg = '0;
    mcu_wdata = '0;
    sd_dat = '0;
    bad = 0;
    load_tests();
    limit = n_tests * TEST_LIMIT + LIMIT_PAD;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst = 1'b0;
    // Idle outputs before the first command
    expect_value("sram_we_n", 1, sram_we_n, bad);
    expect_value("dma_busy", 0, dma_busy, bad);
    expect_value("sd_clk_oe", 0, sd_clk_oe, bad);
    expect_value("sram_addr", 0, sram_addr, bad);
    close_test("reset state", bad);
    if (n_tests == 0) begin
      $display("No test lines could be read from %s", TEST_FILE);
      failed++;
    end
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("Summary: %0d passed, %0d failed, %0d checker errors, %0d SRAM writes",
             passed, failed, chk_errors, chk_writes);
    if (failed == 0 && chk_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- test/sd_dma_checker.sv
`timescale 1ns/10ps

module sd_dma_checker (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 mcu_wr,
  input  sram_pkg::mcu_reg_t   mcu_reg,
  input  sram_pkg::mcu_data_t  mcu_wdata,
  input  sd_bus_pkg::nibble_t  sd_dat,
  input  logic                 sd_clk,
  input  logic                 sd_clk_oe,
  input  sram_pkg::sram_addr_t sram_addr,
  input  sram_pkg::byte_t      sram_data,
  input  logic                 sram_we_n,
  input  logic                 dma_busy,
  output int                   errors,
  output int                   writes
);

  // Start bit, 1024 data nibbles, 16 CRC nibbles and the stop bit
  localparam int PERIODS = 1042;

  int                  base_reg;
  int                  base_l;
  int                  win_start_reg;
  int                  win_end_reg;
  int                  win_lo;
  int                  win_hi;
  int                  byte_idx;
  int                  due_idx;
  int                  period;
  int                  since_rise;
  int                  busy_cycles;
  int                  block_writes;
  logic                partial_reg;
  logic                clk_q;
  logic                we_q;
  logic                busy_q;
  sd_bus_pkg::nibble_t hi_nib;
  sram_pkg::byte_t     exp_byte;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_missing(input int idx);
    $display("error at %0t: byte %0d of the window was never written to SRAM", $time, idx);
    errors++;
  endtask

  always @(posedge CLK) begin
    if (rst) begin
      errors = 0;
      writes = 0;
      base_reg = 0;
      win_start_reg = 0;
      win_end_reg = 0;
      partial_reg = 1'b0;
      due_idx = -1;
      period = 0;
      since_rise = 0;
      clk_q = 1'b0;
      we_q = 1'b1;
      busy_q = 1'b0;
    end else begin
      if (mcu_wr && mcu_reg == sram_pkg::REG_BASE) begin
        base_reg = mcu_wdata;
      end
      if (mcu_wr && mcu_reg == sram_pkg::REG_WIN_START) begin
        win_start_reg = mcu_wdata;
      end
      if (mcu_wr && mcu_reg == sram_pkg::REG_WIN_END) begin
        win_end_reg = mcu_wdata;
      end
      // A command during a transfer is ignored
      if (mcu_wr && mcu_reg == sram_pkg::REG_CMD && !dma_busy) begin
        partial_reg = mcu_wdata[sram_pkg::CMD_PARTIAL_BIT];
      end
      if (dma_busy && !busy_q) begin
        base_l = base_reg;
        win_lo = partial_reg ? win_start_reg : 0;
        win_hi = partial_reg ? win_end_reg : 512;
        due_idx = -1;
        period = 0;
        busy_cycles = 0;
        block_writes = 0;
      end
      if (dma_busy) begin
        busy_cycles++;
      end
      if (!dma_busy && busy_q) begin
        if (busy_cycles != PERIODS * 4) begin
          report_mismatch("dma_busy length", PERIODS * 4, busy_cycles);
        end
        if (period != PERIODS) begin
          report_mismatch("sd_clk periods", PERIODS, period);
        end
        if (due_idx >= 0) begin
          report_missing(due_idx);
          due_idx = -1;
        end
      end
      if (sd_clk_oe !== dma_busy) begin
        report_mismatch("sd_clk_oe", dma_busy, sd_clk_oe);
      end

      //////////////////////////////////////////////////////////////////////////
      // Card bus sampled on the first CLK of each high half of sd_clk
      //////////////////////////////////////////////////////////////////////////
      since_rise++;
      if (sd_clk && sd_clk_oe && !clk_q) begin
        if (period > 0 && since_rise != 4) begin
          report_mismatch("sd_clk period", 4, since_rise);
        end
        since_rise = 0;
        if (period >= 1 && period <= 1024) begin
          if (period % 2 == 1) begin
            hi_nib = sd_dat;
          end else begin
            exp_byte = {hi_nib, sd_dat};
            byte_idx = period / 2 - 1;
            if (due_idx >= 0) begin
              report_missing(due_idx);
            end
            due_idx = (byte_idx >= win_lo && byte_idx < win_hi) ? byte_idx : -1;
          end
        end
        period++;
      end

      // Each write lands at base plus the number of earlier writes
      if (!sram_we_n) begin
        if (!dma_busy) begin
          $display("error at %0t: SRAM write strobe while the DMA is idle", $time);
          errors++;
        end
        if (we_q) begin
          writes++;
          block_writes++;
          if (due_idx < 0) begin
            $display("error at %0t: SRAM write for a byte outside the window", $time);
            errors++;
          end
          due_idx = -1;
        end
        if (sram_data !== exp_byte) begin
          report_mismatch("sram_data", exp_byte, sram_data);
        end
        if (sram_addr !== sram_pkg::sram_addr_t'(base_l + block_writes - 1)) begin
          report_mismatch("sram_addr", base_l + block_writes - 1, sram_addr);
        end
      end
      clk_q = sd_clk;
      we_q = sram_we_n;
      busy_q = dma_busy;
    end
  end

endmodule

//--- verilog/sd_dma_top.sv
`timescale 1ns/10ps

module sd_dma_top (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 mcu_wr,
  input  sram_pkg::mcu_reg_t   mcu_reg,
  input  sram_pkg::mcu_data_t  mcu_wdata,
  input  sd_bus_pkg::nibble_t  sd_dat,
  output logic                 sd_clk,
  output logic                 sd_clk_oe,
  output sram_pkg::sram_addr_t sram_addr,
  output sram_pkg::byte_t      sram_data,
  output logic                 sram_we_n,
  output logic                 dma_busy
);

  sram_pkg::sram_addr_t base;
  logic                 sram_next;

  sd_dma_ctrl_if ctrl_if ();

  assign dma_busy = ctrl_if.busy;

  ////////////////////////////////////////////////////////////////////////////
  // Register block, DMA engine, address counter
  ////////////////////////////////////////////////////////////////////////////

  dma_ctrl u_dma_ctrl (
    .CLK       (CLK),
    .rst       (rst),
    .mcu_wr    (mcu_wr),
    .mcu_reg   (mcu_reg),
    .mcu_wdata (mcu_wdata),
    .ctrl      (ctrl_if.ctrl),
    .base      (base)
  );

  sd_dma u_sd_dma (
    .CLK       (CLK),
    .rst       (rst),
    .ctrl      (ctrl_if.dma),
    .sd_dat    (sd_dat),
    .sd_clk    (sd_clk),
    .sd_clk_oe (sd_clk_oe),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_next (sram_next)
  );

  // Start comes straight from the register block
  sram_addr_gen u_sram_addr_gen (
    .CLK       (CLK),
    .rst       (rst),
    .start     (ctrl_if.start),
    .base      (base),
    .sram_next (sram_next),
    .sram_addr (sram_addr)
  );

endmodule

//--- verilog/sram_addr_gen.sv
`timescale 1ns/10ps

module sram_addr_gen (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 start,
  input  sram_pkg::sram_addr_t base,
  input  logic                 sram_next,
  output sram_pkg::sram_addr_t sram_addr
);

  // Address counter
  // Held through each write, steps after the strobe has gone high again
  always_ff @(posedge CLK) begin
    if (rst) begin
      sram_addr <= '0;
    end else if (start) begin
      sram_addr <= base;
    end else if (sram_next) begin
      sram_addr <= sram_addr + 1'b1;
    end
  end

endmodule

//--- verilog/sd_dma.sv
`timescale 1ns/10ps

module sd_dma (
  input  logic                CLK,
  input  logic                rst,
  sd_dma_ctrl_if.dma          ctrl,
  input  sd_bus_pkg::nibble_t sd_dat,
  output logic                sd_clk,
  output logic                sd_clk_oe,
  output sram_pkg::byte_t     sram_data,
  output logic                sram_we_n,
  output logic                sram_next
);

  sd_bus_pkg::dma_state_t state;
  logic [1:0]             phase;
  logic [1:0]             phase_nxt;
  sd_bus_pkg::sd_cycle_t  period;
  sd_bus_pkg::byte_idx_t  win_lo;
  sd_bus_pkg::byte_idx_t  win_hi;
  sd_bus_pkg::nibble_t    hi_nib;
  sd_bus_pkg::byte_idx_t  byte_idx;
  logic                   run;
  logic                   sample;
  logic                   last_tick;
  logic                   data_period;
  logic                   in_window;

  assign run       = (state == sd_bus_pkg::DMA_RUN);
  assign phase_nxt = phase + 2'd1;

  // Bus is sampled in the last CLK of each SD period, with sd_clk high
  assign sample    = run && (phase == 2'(sd_bus_pkg::CLK_PER_SD - 1));
  assign last_tick = sample && (period == sd_bus_pkg::sd_cycle_t'(sd_bus_pkg::LAST_CYCLE));

  // Periods 1 to 1024 carry the data nibbles
  assign data_period = (period != '0) &&
                       (period <= sd_bus_pkg::sd_cycle_t'(sd_bus_pkg::DATA_NIBBLES));

  // Valid on even periods, which carry a low nibble
  assign byte_idx  = sd_bus_pkg::byte_idx_t'(period >> 1) - 1'b1;
  assign in_window = (byte_idx >= win_lo) && (byte_idx < win_hi);

  assign ctrl.busy = run;
  assign sd_clk_oe = run;

  ////////////////////////////////////////////////////////////////////////////
  // FSM, phase and period counters, SD clock
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      state  <= sd_bus_pkg::DMA_IDLE;
      phase  <= '0;
      period <= '0;
      sd_clk <= 1'b0;
    end else if (ctrl.start) begin
      state  <= sd_bus_pkg::DMA_RUN;
      phase  <= '0;
      period <= '0;
      sd_clk <= 1'b0;
    end else if (run) begin
      phase <= phase_nxt;
      // High during phases 2 and 3
      sd_clk <= phase_nxt[1];
      if (sample) begin
        period <= period + 1'b1;
      end
      if (last_tick) begin
        state <= sd_bus_pkg::DMA_IDLE;
      end
    end
  end

  // Window captured once per transfer
  always_ff @(posedge CLK) begin
    if (ctrl.start) begin
      win_lo <= ctrl.partial ? ctrl.win_start : '0;
      win_hi <= ctrl.partial ? ctrl.win_end :
                               sd_bus_pkg::byte_idx_t'(sd_bus_pkg::BLOCK_BYTES);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte packer, high nibble first
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (sample && data_period) begin
      if (period[0]) begin
        hi_nib <= sd_dat;
      end else begin
        sram_data <= {hi_nib, sd_dat};
      end
    end
  end

  // Two-cycle write strobe, then one advance pulse for the address counter
  always_ff @(posedge CLK) begin
    if (rst) begin
      sram_we_n <= 1'b1;
      sram_next <= 1'b0;
    end else begin
      sram_next <= 1'b0;
      if (sample && data_period && !period[0] && in_window) begin
        sram_we_n <= 1'b0;
      end else if (!sram_we_n && (phase == 2'd1)) begin
        sram_we_n <= 1'b1;
        sram_next <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/dma_ctrl.sv
`timescale 1ns/10ps

module dma_ctrl (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 mcu_wr,
  input  sram_pkg::mcu_reg_t   mcu_reg,
  input  sram_pkg::mcu_data_t  mcu_wdata,
  sd_dma_ctrl_if.ctrl          ctrl,
  output sram_pkg::sram_addr_t base
);

  logic cmd_wr;

  // A command only counts while the engine is idle and no start is pending
  assign cmd_wr = mcu_wr && (mcu_reg == sram_pkg::REG_CMD) &&
                  !ctrl.busy && !ctrl.start;

  ////////////////////////////////////////////////////////////////////////////
  // Command register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      ctrl.start   <= 1'b0;
      ctrl.partial <= 1'b0;
    end else begin
      ctrl.start <= cmd_wr && mcu_wdata[sram_pkg::CMD_START_BIT];
      if (cmd_wr) begin
        ctrl.partial <= mcu_wdata[sram_pkg::CMD_PARTIAL_BIT];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Window and base registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      ctrl.win_start <= '0;
      ctrl.win_end   <= '0;
      base           <= '0;
    end else if (mcu_wr) begin
      case (mcu_reg)
        sram_pkg::REG_WIN_START: ctrl.win_start <= sd_bus_pkg::byte_idx_t'(mcu_wdata);
        sram_pkg::REG_WIN_END:   ctrl.win_end   <= sd_bus_pkg::byte_idx_t'(mcu_wdata);
        sram_pkg::REG_BASE:      base           <= sram_pkg::sram_addr_t'(mcu_wdata);
        default: begin
          // REG_CMD is handled above
        end
      endcase
    end
  end

endmodule

//--- verilog/sd_dma_ctrl_if.sv
`timescale 1ns/10ps

interface sd_dma_ctrl_if;

  // One-cycle transfer request and the window that goes with it
  logic                  start;
  logic                  partial;
  sd_bus_pkg::byte_idx_t win_start;
  sd_bus_pkg::byte_idx_t win_end;

  // High for the whole block read
  logic                  busy;

  modport ctrl (
    output start,
    output partial,
    output win_start,
    output win_end,
    input  busy
  );

  modport dma (
    input  start,
    input  partial,
    input  win_start,
    input  win_end,
    output busy
  );

endinterface

//--- verilog/sram_pkg.sv
package sram_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] sram_addr_t;

  // Microcontroller register bus
  typedef logic [1:0]  mcu_reg_t;
  typedef logic [15:0] mcu_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Control register map
  ////////////////////////////////////////////////////////////////////////////

  localparam mcu_reg_t REG_CMD       = 2'd0;
  localparam mcu_reg_t REG_WIN_START = 2'd1;
  localparam mcu_reg_t REG_WIN_END   = 2'd2;
  localparam mcu_reg_t REG_BASE      = 2'd3;

  // Bits of REG_CMD
  localparam int CMD_START_BIT   = 0;
  localparam int CMD_PARTIAL_BIT = 1;

endpackage

//--- verilog/sd_bus_pkg.sv
package sd_bus_pkg;

  // One sample of the 4-bit SD data bus
  typedef logic [3:0] nibble_t;

  // SD clock period index within one block read
  typedef logic [10:0] sd_cycle_t;

  // Byte index within the block with one extra code for the full-block end
  typedef logic [9:0] byte_idx_t;

  typedef enum logic {
    DMA_IDLE,
    DMA_RUN
  } dma_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Block read timing
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_PER_SD   = 4;
  localparam int BLOCK_BYTES  = 512;
  localparam int DATA_NIBBLES = 2 * BLOCK_BYTES;
  localparam int CRC_NIBBLES  = 16;

  // Start bit, data nibbles, CRC nibbles, then the stop bit period
  localparam int LAST_CYCLE   = 1 + DATA_NIBBLES + CRC_NIBBLES;

endpackage
